// ==== hw/mips_pkg.sv ====
package mips_pkg;

	// One instruction word, read either as an R-type or an I-type layout.
	typedef union packed {
		struct packed {
			logic [5:0] opcode;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} r;
		struct packed {
			logic [5:0] opcode;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [15:0] imm;
		} i;
	} instr_t;

	localparam logic [5:0] op_special = 6'h00;
	localparam logic [5:0] op_jal = 6'h03;
	localparam logic [5:0] op_addiu = 6'h09;
	localparam logic [5:0] op_ori = 6'h0d;
	localparam logic [5:0] op_lui = 6'h0f;
	localparam logic [5:0] op_lwl = 6'h22;
	localparam logic [5:0] op_lw = 6'h23;
	localparam logic [5:0] op_lwr = 6'h26;

	localparam logic [5:0] fn_sll = 6'h00;
	localparam logic [5:0] fn_srl = 6'h02;
	localparam logic [5:0] fn_jalr = 6'h09;
	localparam logic [5:0] fn_addu = 6'h21;
	localparam logic [5:0] fn_subu = 6'h23;
	localparam logic [5:0] fn_and = 6'h24;
	localparam logic [5:0] fn_or = 6'h25;
	localparam logic [5:0] fn_xor = 6'h26;
	localparam logic [5:0] fn_slt = 6'h2a;
	localparam logic [5:0] fn_sltu = 6'h2b;

	localparam int alu_op_w = 4;

	localparam logic [alu_op_w-1:0] alu_add = 4'd0;
	localparam logic [alu_op_w-1:0] alu_sub = 4'd1;
	localparam logic [alu_op_w-1:0] alu_and = 4'd2;
	localparam logic [alu_op_w-1:0] alu_or = 4'd3;
	localparam logic [alu_op_w-1:0] alu_xor = 4'd4;
	localparam logic [alu_op_w-1:0] alu_slt = 4'd5;
	localparam logic [alu_op_w-1:0] alu_sltu = 4'd6;
	localparam logic [alu_op_w-1:0] alu_sll = 4'd7;
	localparam logic [alu_op_w-1:0] alu_srl = 4'd8;
	localparam logic [alu_op_w-1:0] alu_lui = 4'd9;

	localparam int res_sel_w = 2;

	localparam logic [res_sel_w-1:0] res_alu = 2'd0;
	localparam logic [res_sel_w-1:0] res_link = 2'd1;
	localparam logic [res_sel_w-1:0] res_load = 2'd2;

endpackage

// ==== hw/mips_control.sv ====
`timescale 1ns/1ps

module mips_control #(
	parameter logic [31:0] RESET_PC = 32'hbfc00000
) (
	input  logic clk,
	input  logic reset,
	input  logic [31:0] instr,
	input  logic instr_valid,
	input  logic mem_rvalid,
	input  logic [31:0] alu_result,
	input  logic [31:0] read_data_1,
	output logic ready,
	output logic done,
	output logic mem_read,
	output logic [31:0] mem_addr,
	output logic [31:0] pc,
	output logic [4:0] read_addr_1,
	output logic [4:0] read_addr_2,
	output logic read_strobe,
	output logic [mips_pkg::alu_op_w-1:0] alu_op,
	output logic use_imm,
	output logic [31:0] imm_value,
	output logic [4:0] shamt,
	output logic [mips_pkg::res_sel_w-1:0] res_sel,
	output logic [5:0] load_kind,
	output logic [31:0] link_value,
	output logic load_capture,
	output logic write_en,
	output logic [4:0] write_addr
);

	localparam logic [2:0] st_idle = 3'd0;
	localparam logic [2:0] st_read = 3'd1;
	localparam logic [2:0] st_exec = 3'd2;
	localparam logic [2:0] st_mem = 3'd3;
	localparam logic [2:0] st_write = 3'd4;

	logic [2:0] state;
	logic req_sent;
	mips_pkg::instr_t instr_q;
	logic [5:0] opcode;
	logic [5:0] funct;
	logic is_special;
	logic is_load;
	logic is_jal;
	logic is_jalr;
	logic [31:0] pc_plus4;
	logic [25:0] jump_target;

	assign opcode = instr_q.i.opcode;
	assign funct = instr_q.r.funct;
	assign is_special = opcode == mips_pkg::op_special;
	assign is_load = opcode == mips_pkg::op_lw || opcode == mips_pkg::op_lwl ||
		opcode == mips_pkg::op_lwr;
	assign is_jal = opcode == mips_pkg::op_jal;
	assign is_jalr = is_special && funct == mips_pkg::fn_jalr;
	assign jump_target = {instr_q.i.rs, instr_q.i.rt, instr_q.i.imm};

	assign ready = state == st_idle;
	assign read_strobe = state == st_read;
	assign done = state == st_write;
	assign write_en = state == st_write;

	// The request goes out only in the first MEM cycle, while later MEM cycles just wait.
	assign mem_read = state == st_mem && !req_sent;
	assign mem_addr = alu_result;
	assign load_capture = state == st_mem && mem_rvalid;

	assign read_addr_1 = instr_q.i.rs;
	assign read_addr_2 = instr_q.i.rt;
	assign shamt = instr_q.r.shamt;
	assign use_imm = !is_special;
	assign load_kind = opcode;
	assign pc_plus4 = pc + 32'd4;
	assign link_value = pc + 32'd8;

	always_comb begin
		case (opcode)
			mips_pkg::op_ori: imm_value = {16'h0000, instr_q.i.imm};
			mips_pkg::op_lui: imm_value = {instr_q.i.imm, 16'h0000};
			default: imm_value = {{16{instr_q.i.imm[15]}}, instr_q.i.imm};
		endcase
	end

	always_comb begin
		if (is_special) begin
			case (funct)
				mips_pkg::fn_subu: alu_op = mips_pkg::alu_sub;
				mips_pkg::fn_and: alu_op = mips_pkg::alu_and;
				mips_pkg::fn_or: alu_op = mips_pkg::alu_or;
				mips_pkg::fn_xor: alu_op = mips_pkg::alu_xor;
				mips_pkg::fn_slt: alu_op = mips_pkg::alu_slt;
				mips_pkg::fn_sltu: alu_op = mips_pkg::alu_sltu;
				mips_pkg::fn_sll: alu_op = mips_pkg::alu_sll;
				mips_pkg::fn_srl: alu_op = mips_pkg::alu_srl;
				default: alu_op = mips_pkg::alu_add;
			endcase
		end else begin
			case (opcode)
				mips_pkg::op_ori: alu_op = mips_pkg::alu_or;
				mips_pkg::op_lui: alu_op = mips_pkg::alu_lui;
				default: alu_op = mips_pkg::alu_add;
			endcase
		end
	end

	always_comb begin
		if (is_jal || is_jalr) begin
			res_sel = mips_pkg::res_link;
		end else if (is_load) begin
			res_sel = mips_pkg::res_load;
		end else begin
			res_sel = mips_pkg::res_alu;
		end
	end

	// JAL links through r31 and R-types write rd.
	always_comb begin
		if (is_jal) begin
			write_addr = 5'd31;
		end else if (is_special) begin
			write_addr = instr_q.r.rd;
		end else begin
			write_addr = instr_q.i.rt;
		end
	end

	always_ff @(posedge clk) begin
		if (ready && instr_valid) begin
			instr_q <= instr;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
			req_sent <= 1'b0;
			pc <= RESET_PC;
		end else begin
			req_sent <= state == st_mem;
			case (state)
				st_idle: begin
					if (instr_valid) begin
						state <= st_read;
					end
				end
				st_read: state <= st_exec;
				st_exec: state <= is_load ? st_mem : st_write;
				st_mem: begin
					if (mem_rvalid) begin
						state <= st_write;
					end
				end
				st_write: begin
					state <= st_idle;
					if (is_jal) begin
						pc <= {pc_plus4[31:28], jump_target, 2'b00};
					end else if (is_jalr) begin
						pc <= read_data_1;
					end else begin
						pc <= pc_plus4;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	mem_read_single_cycle: assert property (@(posedge clk) disable iff (reset)
		mem_read |=> !mem_read)
		else $error("mem_read stayed high for more than one cycle.");

	rvalid_only_in_mem: assert property (@(posedge clk) disable iff (reset)
		mem_rvalid |-> state == st_mem)
		else $error("mem_rvalid arrived while no load was waiting for data.");

endmodule

// ==== hw/mips_regfile.sv ====
`timescale 1ns/1ps

module mips_regfile (
	input  logic clk,
	input  logic reset,
	input  logic [4:0] read_addr_1,
	input  logic [4:0] read_addr_2,
	input  logic read_strobe,
	input  logic write_en,
	input  logic [4:0] write_addr,
	input  logic [31:0] write_data,
	output logic [31:0] read_data_1,
	output logic [31:0] read_data_2,
	output logic [31:0] register_v0
);

	logic [31:0] regs [32];

	assign register_v0 = regs[2];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int idx = 0; idx < 32; idx++) begin
				regs[idx] <= '0;
			end
			read_data_1 <= '0;
			read_data_2 <= '0;
		end else begin
			// r0 stays zero, so a write aimed at it is simply lost.
			if (write_en && write_addr != 5'd0) begin
				regs[write_addr] <= write_data;
			end
			if (read_strobe) begin
				read_data_1 <= regs[read_addr_1];
				read_data_2 <= regs[read_addr_2];
			end
		end
	end

	read_write_apart: assert property (@(posedge clk) disable iff (reset)
		!(read_strobe && write_en))
		else $error("Register read and write were requested in the same cycle.");

endmodule

// ==== hw/mips_alu.sv ====
`timescale 1ns/1ps

module mips_alu (
	input  logic clk,
	input  logic reset,
	input  logic [mips_pkg::alu_op_w-1:0] alu_op,
	input  logic [31:0] read_data_1,
	input  logic [31:0] read_data_2,
	input  logic use_imm,
	input  logic [31:0] imm_value,
	input  logic [4:0] shamt,
	output logic [31:0] alu_result
);

	logic [31:0] operand_b;
	logic [31:0] result;

	assign operand_b = use_imm ? imm_value : read_data_2;

	always_comb begin
		case (alu_op)
			mips_pkg::alu_add: result = read_data_1 + operand_b;
			mips_pkg::alu_sub: result = read_data_1 - operand_b;
			mips_pkg::alu_and: result = read_data_1 & operand_b;
			mips_pkg::alu_or: result = read_data_1 | operand_b;
			mips_pkg::alu_xor: result = read_data_1 ^ operand_b;
			mips_pkg::alu_slt: begin
				result = {31'd0, $signed(read_data_1) < $signed(operand_b)};
			end
			mips_pkg::alu_sltu: result = {31'd0, read_data_1 < operand_b};
			// Shifts act on rt and take their amount from the instruction.
			mips_pkg::alu_sll: result = operand_b << shamt;
			mips_pkg::alu_srl: result = operand_b >> shamt;
			mips_pkg::alu_lui: result = operand_b;
			default: result = read_data_1 + operand_b;
		endcase
	end

	// Operands hold still from EXEC onward, so the result stays put through WRITE.
	always_ff @(posedge clk) begin
		if (reset) begin
			alu_result <= '0;
		end else begin
			alu_result <= result;
		end
	end

endmodule

// ==== hw/mips_writeback.sv ====
`timescale 1ns/1ps

module mips_writeback (
	input  logic clk,
	input  logic reset,
	input  logic [mips_pkg::res_sel_w-1:0] res_sel,
	input  logic [5:0] load_kind,
	input  logic load_capture,
	input  logic [31:0] mem_rdata,
	input  logic [1:0] byte_offset,
	input  logic [31:0] old_value,
	input  logic [31:0] alu_result,
	input  logic [31:0] link_value,
	output logic [31:0] write_data
);

	logic [31:0] load_data;
	logic [31:0] load_result;

	always_ff @(posedge clk) begin
		if (reset) begin
			load_data <= '0;
		end else if (load_capture) begin
			load_data <= mem_rdata;
		end
	end

	// Big-endian order puts byte 0 in the most significant position.
	always_comb begin
		load_result = load_data;
		if (load_kind == mips_pkg::op_lwl) begin
			case (byte_offset)
				2'd0: load_result = load_data;
				2'd1: load_result = {load_data[23:0], old_value[7:0]};
				2'd2: load_result = {load_data[15:0], old_value[15:0]};
				default: load_result = {load_data[7:0], old_value[23:0]};
			endcase
		end else if (load_kind == mips_pkg::op_lwr) begin
			case (byte_offset)
				2'd0: load_result = {old_value[31:8], load_data[31:24]};
				2'd1: load_result = {old_value[31:16], load_data[31:16]};
				2'd2: load_result = {old_value[31:24], load_data[31:8]};
				default: load_result = load_data;
			endcase
		end
	end

	always_comb begin
		case (res_sel)
			mips_pkg::res_link: write_data = link_value;
			mips_pkg::res_load: write_data = load_result;
			default: write_data = alu_result;
		endcase
	end

endmodule

// ==== hw/mips_core.sv ====
`timescale 1ns/1ps

module mips_core #(
	parameter logic [31:0] RESET_PC = 32'hbfc00000
) (
	input  logic clk,
	input  logic reset,
	input  logic [31:0] instr,
	input  logic instr_valid,
	input  logic [31:0] mem_rdata,
	input  logic mem_rvalid,
	output logic ready,
	output logic done,
	output logic mem_read,
	output logic [31:0] mem_addr,
	output logic [31:0] pc,
	output logic [31:0] register_v0
);

	logic [4:0] read_addr_1;
	logic [4:0] read_addr_2;
	logic read_strobe;
	logic [31:0] read_data_1;
	logic [31:0] read_data_2;
	logic [mips_pkg::alu_op_w-1:0] alu_op;
	logic use_imm;
	logic [31:0] imm_value;
	logic [4:0] shamt;
	logic [31:0] alu_result;
	logic [mips_pkg::res_sel_w-1:0] res_sel;
	logic [5:0] load_kind;
	logic [31:0] link_value;
	logic load_capture;
	logic write_en;
	logic [4:0] write_addr;
	logic [31:0] write_data;

	mips_control #(
		.RESET_PC(RESET_PC)
	) control_inst (
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.instr_valid(instr_valid),
		.mem_rvalid(mem_rvalid),
		.alu_result(alu_result),
		.read_data_1(read_data_1),
		.ready(ready),
		.done(done),
		.mem_read(mem_read),
		.mem_addr(mem_addr),
		.pc(pc),
		.read_addr_1(read_addr_1),
		.read_addr_2(read_addr_2),
		.read_strobe(read_strobe),
		.alu_op(alu_op),
		.use_imm(use_imm),
		.imm_value(imm_value),
		.shamt(shamt),
		.res_sel(res_sel),
		.load_kind(load_kind),
		.link_value(link_value),
		.load_capture(load_capture),
		.write_en(write_en),
		.write_addr(write_addr)
	);

	mips_regfile regfile_inst (
		.clk(clk),
		.reset(reset),
		.read_addr_1(read_addr_1),
		.read_addr_2(read_addr_2),
		.read_strobe(read_strobe),
		.write_en(write_en),
		.write_addr(write_addr),
		.write_data(write_data),
		.read_data_1(read_data_1),
		.read_data_2(read_data_2),
		.register_v0(register_v0)
	);

	mips_alu alu_inst (
		.clk(clk),
		.reset(reset),
		.alu_op(alu_op),
		.read_data_1(read_data_1),
		.read_data_2(read_data_2),
		.use_imm(use_imm),
		.imm_value(imm_value),
		.shamt(shamt),
		.alu_result(alu_result)
	);

	// The old rt value feeds the partial-word merge of LWL and LWR.
	mips_writeback writeback_inst (
		.clk(clk),
		.reset(reset),
		.res_sel(res_sel),
		.load_kind(load_kind),
		.load_capture(load_capture),
		.mem_rdata(mem_rdata),
		.byte_offset(mem_addr[1:0]),
		.old_value(read_data_2),
		.alu_result(alu_result),
		.link_value(link_value),
		.write_data(write_data)
	);

endmodule

// ==== dv/mips_core_tb.sv ====
`timescale 1ns/1ps

module mips_core_tb;

	localparam logic [31:0] reset_pc = 32'hbfc00000;
	// About 80 instructions of at most 12 cycles each, plus margin.
	localparam int cycle_limit = 80 * 12 + 240;

	logic clk;
	logic reset;
	logic [31:0] instr;
	logic instr_valid;
	logic [31:0] mem_rdata;
	logic mem_rvalid;
	logic ready;
	logic done;
	logic mem_read;
	logic [31:0] mem_addr;
	logic [31:0] pc;
	logic [31:0] register_v0;

	logic [31:0] exp_regs [32];
	logic [31:0] exp_pc;
	logic [31:0] exp_v0;
	logic [31:0] exp_addr;
	logic [31:0] rnd;
	integer seed;
	int error_count = 0;
	int cycle_count = 0;
	int issue_count = 0;
	int done_count = 0;

	mips_core mips_core_inst (
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.instr_valid(instr_valid),
		.mem_rdata(mem_rdata),
		.mem_rvalid(mem_rvalid),
		.ready(ready),
		.done(done),
		.mem_read(mem_read),
		.mem_addr(mem_addr),
		.pc(pc),
		.register_v0(register_v0)
	);

	always #20 clk = ~clk;

	function automatic logic [31:0] build_rtype(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [4:0] sa, input logic [5:0] fn);
		return {mips_pkg::op_special, rs, rt, rd, sa, fn};
	endfunction

	function automatic logic [31:0] build_itype(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic is_load_word(input logic [31:0] w);
		return w[31:26] == mips_pkg::op_lw || w[31:26] == mips_pkg::op_lwl ||
			w[31:26] == mips_pkg::op_lwr;
	endfunction

	// Memory contents depend on the whole word address.
	function automatic logic [31:0] mem_word(input logic [31:0] addr);
		logic [31:0] a;
		a = {addr[31:2], 2'b00};
		return (a * 32'h9e3779b1) ^ 32'h5a5a0f0f;
	endfunction

	task automatic apply_model(input logic [31:0] w);
		logic [5:0] op;
		logic [4:0] dest;
		logic [15:0] imm;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] sext;
		logic [31:0] result;
		logic [31:0] next_pc;
		logic [31:0] data;
		int k;
		op = w[31:26];
		imm = w[15:0];
		a = exp_regs[w[25:21]];
		b = exp_regs[w[20:16]];
		sext = {{16{imm[15]}}, imm};
		next_pc = exp_pc + 32'd4;
		dest = w[20:16];
		result = 32'd0;
		if (op == mips_pkg::op_special) begin
			dest = w[15:11];
			case (w[5:0])
				mips_pkg::fn_addu: result = a + b;
				mips_pkg::fn_subu: result = a - b;
				mips_pkg::fn_and: result = a & b;
				mips_pkg::fn_or: result = a | b;
				mips_pkg::fn_xor: result = a ^ b;
				mips_pkg::fn_slt: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				mips_pkg::fn_sltu: result = (a < b) ? 32'd1 : 32'd0;
				mips_pkg::fn_sll: result = b << w[10:6];
				mips_pkg::fn_srl: result = b >> w[10:6];
				mips_pkg::fn_jalr: begin
					result = exp_pc + 32'd8;
					next_pc = a;
				end
				default: result = 32'd0;
			endcase
		end else begin
			case (op)
				mips_pkg::op_addiu: result = a + sext;
				mips_pkg::op_ori: result = a | {16'h0000, imm};
				mips_pkg::op_lui: result = {imm, 16'h0000};
				mips_pkg::op_jal: begin
					dest = 5'd31;
					result = exp_pc + 32'd8;
					next_pc = {next_pc[31:28], w[25:0], 2'b00};
				end
				default: begin
					exp_addr = a + sext;
					data = mem_word(exp_addr);
					k = int'(exp_addr[1:0]);
					result = b;
					// Byte i of memory is data[31-8i -: 8].
					if (op == mips_pkg::op_lw) begin
						result = data;
					end else if (op == mips_pkg::op_lwl) begin
						for (int i = k; i < 4; i++) begin
							result[31-8*(i-k) -: 8] = data[31-8*i -: 8];
						end
					end else begin
						for (int i = 0; i <= k; i++) begin
							result[8*(k-i)+7 -: 8] = data[31-8*i -: 8];
						end
					end
				end
			endcase
		end
		if (dest != 5'd0) begin
			exp_regs[dest] = result;
		end
		exp_pc = next_pc;
		exp_v0 = exp_regs[2];
	endtask

	// Holds instr_valid until an edge with ready high takes the word.
	task automatic issue(input logic [31:0] w);
		logic seen;
		instr <= w;
		instr_valid <= 1'b1;
		seen = 1'b0;
		while (!seen) begin
			@(negedge clk);
			seen = ready;
			@(posedge clk);
		end
		apply_model(w);
		issue_count++;
	endtask

	task automatic move_to_v0(input logic [4:0] r);
		issue(build_rtype(r, 5'd0, 5'd2, 5'd0, mips_pkg::fn_addu));
	endtask

	task automatic load_constant(input logic [4:0] r, input logic [31:0] value);
		issue(build_itype(mips_pkg::op_lui, 5'd0, r, value[31:16]));
		issue(build_itype(mips_pkg::op_ori, r, r, value[15:0]));
	endtask

	task automatic alu_and_move(input logic [31:0] w);
		issue(w);
		move_to_v0(5'd20);
	endtask

	initial begin : memory_responder
		logic [31:0] addr;
		logic [31:0] draw;
		int delay;
		forever begin
			@(negedge clk);
			if (mem_read) begin
				addr = mem_addr;
				draw = $random(seed);
				delay = int'(draw % 32'd6);
				@(posedge clk);
				repeat (delay) @(posedge clk);
				mem_rvalid <= 1'b1;
				mem_rdata <= mem_word(addr);
				@(posedge clk);
				mem_rvalid <= 1'b0;
			end
		end
	end

	always @(posedge clk) begin
		if (!reset && done) begin
			done_count <= done_count + 1;
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout, the run did not finish within %0d cycles.", cycle_limit);
			$display("Errors: %0d", error_count);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	reset_flags_ok: assert property (@(posedge clk) $fell(reset) |->
		ready && !done && !mem_read)
		else begin
			error_count++;
			$display("Mismatch ready/done/mem_read after reset: expected 1/0/0, actual %h/%h/%h",
				$sampled(ready), $sampled(done), $sampled(mem_read));
		end

	reset_v0_ok: assert property (@(posedge clk) $fell(reset) |-> register_v0 == 32'd0)
		else begin
			error_count++;
			$display("Mismatch register_v0 after reset: expected %h, actual %h",
				32'd0, $sampled(register_v0));
		end

	reset_pc_ok: assert property (@(posedge clk) $fell(reset) |-> pc == reset_pc)
		else begin
			error_count++;
			$display("Mismatch pc after reset: expected %h, actual %h", reset_pc, $sampled(pc));
		end

	v0_ok: assert property (@(posedge clk) disable iff (reset)
		done |=> register_v0 == exp_v0)
		else begin
			error_count++;
			$display("Mismatch register_v0: expected %h, actual %h",
				$sampled(exp_v0), $sampled(register_v0));
		end

	pc_ok: assert property (@(posedge clk) disable iff (reset)
		done |=> pc == exp_pc)
		else begin
			error_count++;
			$display("Mismatch pc: expected %h, actual %h", $sampled(exp_pc), $sampled(pc));
		end

	addr_ok: assert property (@(posedge clk) disable iff (reset)
		mem_read |-> mem_addr == exp_addr)
		else begin
			error_count++;
			$display("Mismatch mem_addr: expected %h, actual %h",
				$sampled(exp_addr), $sampled(mem_addr));
		end

	latency_ok: assert property (@(posedge clk) disable iff (reset)
		$past(ready && instr_valid && !is_load_word(instr), 3) |-> done)
		else begin
			error_count++;
			$display("done did not come three cycles after a non-load was accepted.");
		end

	initial begin
		seed = 4;
		clk = 1'b0;
		reset = 1'b1;
		instr = 32'd0;
		instr_valid = 1'b0;
		mem_rdata = 32'd0;
		mem_rvalid = 1'b0;
		for (int r = 0; r < 32; r++) begin
			exp_regs[r] = 32'd0;
		end
		exp_pc = reset_pc;
		exp_v0 = 32'd0;
		exp_addr = 32'd0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;

		for (int r = 8; r < 16; r++) begin
			rnd = $random(seed);
			load_constant(5'(r), rnd);
		end
		alu_and_move(build_rtype(5'd8, 5'd9, 5'd20, 5'd0, mips_pkg::fn_addu));
		alu_and_move(build_rtype(5'd10, 5'd11, 5'd20, 5'd0, mips_pkg::fn_subu));
		alu_and_move(build_rtype(5'd12, 5'd13, 5'd20, 5'd0, mips_pkg::fn_and));
		alu_and_move(build_rtype(5'd14, 5'd15, 5'd20, 5'd0, mips_pkg::fn_or));
		alu_and_move(build_rtype(5'd8, 5'd11, 5'd20, 5'd0, mips_pkg::fn_xor));
		alu_and_move(build_rtype(5'd9, 5'd12, 5'd20, 5'd0, mips_pkg::fn_slt));
		alu_and_move(build_rtype(5'd12, 5'd9, 5'd20, 5'd0, mips_pkg::fn_slt));
		alu_and_move(build_rtype(5'd10, 5'd14, 5'd20, 5'd0, mips_pkg::fn_sltu));
		rnd = $random(seed);
		alu_and_move(build_rtype(5'd0, 5'd13, 5'd20, rnd[4:0], mips_pkg::fn_sll));
		alu_and_move(build_rtype(5'd0, 5'd15, 5'd20, rnd[9:5], mips_pkg::fn_srl));
		alu_and_move(build_itype(mips_pkg::op_addiu, 5'd11, 5'd20, rnd[31:16]));
		alu_and_move(build_itype(mips_pkg::op_ori, 5'd8, 5'd20, rnd[15:0]));
		alu_and_move(build_itype(mips_pkg::op_lui, 5'd0, 5'd20, rnd[23:8]));

		// r0 must read back as zero after both kinds of write.
		issue(build_itype(mips_pkg::op_addiu, 5'd8, 5'd0, 16'h1234));
		move_to_v0(5'd0);
		issue(build_rtype(5'd8, 5'd9, 5'd0, 5'd0, mips_pkg::fn_or));
		move_to_v0(5'd0);

		load_constant(5'd24, 32'h10000100);
		for (int k = 0; k < 4; k++) begin
			issue(build_itype(mips_pkg::op_lwl, 5'd24, 5'd10, 16'hfff8 + 16'(k)));
			move_to_v0(5'd10);
			issue(build_itype(mips_pkg::op_lwr, 5'd24, 5'd11, 16'h0010 + 16'(k)));
			move_to_v0(5'd11);
			issue(build_itype(mips_pkg::op_lw, 5'd24, 5'd12, 16'(4 * k)));
			move_to_v0(5'd12);
		end

		rnd = $random(seed);
		issue({mips_pkg::op_jal, rnd[25:0]});
		move_to_v0(5'd31);
		issue(build_rtype(5'd13, 5'd0, 5'd12, 5'd0, mips_pkg::fn_jalr));
		move_to_v0(5'd12);

		instr_valid <= 1'b0;
		while (done_count < issue_count) begin
			@(posedge clk);
		end
		repeat (2) @(posedge clk);
		if (done_count != issue_count) begin
			error_count++;
			$display("Saw %0d done pulses for %0d instructions.", done_count, issue_count);
		end
		$display("Errors: %0d", error_count);
		if (error_count == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== mips_core.f ====
hw/mips_pkg.sv
hw/mips_control.sv
hw/mips_regfile.sv
hw/mips_alu.sv
hw/mips_writeback.sv
hw/mips_core.sv
dv/mips_core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module mips_core_tb \
	--Mdir obj_dir \
	-o mips_core_sim \
	-f mips_core.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed."
	exit 1
fi

output="$(./obj_dir/mips_core_sim)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status."
	exit 1
fi

if echo "$output" | grep -qx "ALL TESTS PASSED"; then
	exit 0
else
	exit 1
fi
